// File: flist.f
icache_geom_pkg.sv
icache_fetch_pkg.sv
icache_array_if.sv
icache_tag_array.sv
icache_data_array.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
icache_sva.sv
tb_icache.sv

// File: icache_array_if.sv
// Array access interface between control, refill unit, tag array and data array
`timescale 1ns/1ps
`default_nettype none

interface icache_array_if #(
  parameter int unsigned WaysWidth = 2
);

  // Lookup side, driven by control
  logic                         rd_req;
  icache_geom_pkg::icache_addr_u rd_addr;
  logic                         flush_start;
  logic                         alloc;

  // Refill writes
  logic                         wr_tag_req;
  logic                         wr_data_req;
  logic [WaysWidth-1:0]         wr_way;
  icache_geom_pkg::icache_addr_u wr_addr;
  icache_geom_pkg::tag_entry_t  wr_tag;
  logic [63:0]                  wr_data;

  // Lookup results, valid the cycle after rd_req
  logic                         hit;
  logic [WaysWidth-1:0]         sel_way;
  logic                         flush_busy;
  logic [31:0]                  rd_word;

  modport ctrl (
    output rd_req, rd_addr, flush_start, alloc,
    input  hit, sel_way, flush_busy, rd_word
  );

  modport refill (
    output wr_tag_req, wr_data_req, wr_way, wr_addr, wr_tag, wr_data,
    input  rd_addr
  );

  modport tag (
    input  rd_req, rd_addr, flush_start, alloc, wr_tag_req, wr_way, wr_addr, wr_tag,
    output hit, sel_way, flush_busy
  );

  modport data (
    input  rd_req, rd_addr, sel_way, wr_data_req, wr_way, wr_addr, wr_data,
    output rd_word
  );

endinterface

`default_nettype wire

// File: icache_ctrl.sv
// Fetch FSM sequencing flush, lookup, refill and exception responses
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
  parameter int unsigned WaysWidth = 2
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 req_valid_i,
  input  wire logic [63:0]          req_addr_i,
  input  wire logic                 req_flush_i,
  output logic                      resp_valid_o,
  output logic [31:0]               resp_instr_o,
  output logic                      resp_exception_o,
  output logic [3:0]                resp_ex_code_o,
  icache_array_if.ctrl              arr,
  output logic                      refill_start_o,
  output logic [WaysWidth-1:0]      refill_way_o,
  input  wire logic                 refill_done_i,
  input  wire logic                 refill_denied_i
);

  typedef enum logic [2:0] {
    WaitFlush,
    Idle,
    Fetch,
    Fill,
    Replay,
    Exception
  } state_e;

  state_e                        state_q, state_d;
  icache_geom_pkg::icache_addr_u addr_q, addr_d;
  logic                          oor_q, oor_d;
  logic                          pending_q, pending_d;

  logic req_oor;
  logic lookup_free;

  // Anything above the physical address width is an access fault
  assign req_oor = |req_addr_i[63:icache_geom_pkg::PhysAddrLen];

  // A new request can go straight to the arrays
  assign lookup_free = state_q == Idle ||
                       (state_q == WaitFlush && !arr.flush_busy && !pending_q);

  always_comb begin
    state_d          = state_q;
    addr_d           = addr_q;
    oor_d            = oor_q;
    pending_d        = pending_q;
    arr.rd_req       = 1'b0;
    arr.rd_addr      = addr_q;
    arr.flush_start  = 1'b0;
    arr.alloc        = 1'b0;
    refill_start_o   = 1'b0;
    resp_valid_o     = 1'b0;
    resp_exception_o = 1'b0;

    unique case (state_q)
      WaitFlush: begin
        if (!arr.flush_busy && pending_q) begin
          pending_d = 1'b0;
          if (oor_q) begin
            state_d = Exception;
          end else begin
            arr.rd_req = 1'b1;
            state_d    = Fetch;
          end
        end else if (!arr.flush_busy && !req_valid_i) begin
          state_d = Idle;
        end
      end
      Fetch: begin
        if (arr.hit) begin
          resp_valid_o = 1'b1;
          state_d      = Idle;
        end else begin
          // Refill picks up the line address from rd_addr this cycle
          arr.alloc      = 1'b1;
          refill_start_o = 1'b1;
          state_d        = Fill;
        end
      end
      Fill: begin
        if (refill_done_i) begin
          state_d = refill_denied_i ? Exception : Replay;
        end
      end
      Replay: begin
        arr.rd_req = 1'b1;
        state_d    = Fetch;
      end
      Exception: begin
        resp_valid_o     = 1'b1;
        resp_exception_o = 1'b1;
        state_d          = Idle;
      end
      default: ;
    endcase

    ////////////////////////////////
    // New request
    ////////////////////////////////

    if (req_valid_i && (state_q == Idle || state_q == WaitFlush)) begin
      addr_d.raw = req_addr_i[icache_geom_pkg::PhysAddrLen-1:0];
      oor_d      = req_oor;
      if (req_flush_i) begin
        arr.flush_start = 1'b1;
        pending_d       = 1'b1;
        state_d         = WaitFlush;
      end else if (lookup_free) begin
        if (req_oor) begin
          state_d = Exception;
        end else begin
          arr.rd_req  = 1'b1;
          arr.rd_addr = addr_d;
          state_d     = Fetch;
        end
      end else begin
        // Sweep still running, hold until it ends
        pending_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= WaitFlush;
      oor_q     <= 1'b0;
      pending_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      oor_q     <= oor_d;
      pending_q <= pending_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
  end

  assign refill_way_o   = arr.sel_way;
  assign resp_instr_o   = arr.rd_word;
  assign resp_ex_code_o = resp_exception_o ? icache_fetch_pkg::ExcAccessFault : 4'd0;

endmodule

`default_nettype wire

// File: icache_data_array.sv
// Data RAMs per way, way select and 32-bit half select
`timescale 1ns/1ps
`default_nettype none

module icache_data_array #(
  parameter int unsigned WaysWidth = 2
) (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  icache_array_if.data arr
);

  localparam int unsigned RowWidth = icache_geom_pkg::SetsWidth + icache_geom_pkg::BeatWidth;
  localparam int unsigned NumWays  = 2 ** WaysWidth;
  localparam int unsigned NumRows  = 2 ** RowWidth;

  logic [63:0] data_mem [NumWays][NumRows];
  logic [63:0] rd_data_q [NumWays];
  logic        half_q;

  // Row is set index plus beat within the line
  logic [RowWidth-1:0] rd_row;
  logic [RowWidth-1:0] wr_row;
  logic [63:0]         way_data;

  assign rd_row = {arr.rd_addr.fields.index, arr.rd_addr.fields.beat};
  assign wr_row = {arr.wr_addr.fields.index, arr.wr_addr.fields.beat};

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NumWays; w++) begin
      if (arr.wr_data_req && arr.wr_way == WaysWidth'(w)) begin
        data_mem[w][wr_row] <= arr.wr_data;
      end
      if (arr.rd_req) begin
        rd_data_q[w] <= data_mem[w][rd_row];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      half_q <= 1'b0;
    end else if (arr.rd_req) begin
      half_q <= arr.rd_addr.fields.half;
    end
  end

  // Way comes from the tag array in the same cycle as the data
  assign way_data    = rd_data_q[arr.sel_way];
  assign arr.rd_word = half_q ? way_data[63:32] : way_data[31:0];

endmodule

`default_nettype wire

// File: icache_fetch_pkg.sv
// Fetch-side exception cause codes and refill beat constants
`default_nettype none

package icache_fetch_pkg;

  ////////////////////////////////
  // Exception causes
  ////////////////////////////////

  // Instruction access fault, also used for out-of-range addresses
  parameter logic [3:0] ExcAccessFault = 4'd1;

  ////////////////////////////////
  // Refill
  ////////////////////////////////

  // 64-bit beats in one 64-byte line
  parameter int unsigned BeatsPerLine = 8;

endpackage

`default_nettype wire

// File: icache_geom_pkg.sv
// Cache geometry constants, the fetch address union and the tag entry type
`default_nettype none

package icache_geom_pkg;

  // Physical address and line geometry
  parameter int unsigned PhysAddrLen = 32;
  parameter int unsigned SetsWidth   = 4;
  parameter int unsigned BeatWidth   = 3;
  // 64-byte line, so six offset bits drop out of the tag
  parameter int unsigned TagWidth    = PhysAddrLen - SetsWidth - 6;

  typedef struct packed {
    logic [TagWidth-1:0]  tag;
    logic [SetsWidth-1:0] index;
    logic [BeatWidth-1:0] beat;
    logic                 half;
    logic [1:0]           byte_off;
  } icache_addr_fields_t;

  // Same word seen flat by memory and split by the arrays
  typedef union packed {
    logic [PhysAddrLen-1:0] raw;
    icache_addr_fields_t    fields;
  } icache_addr_u;

  typedef struct packed {
    logic [TagWidth-1:0] tag;
    logic                valid;
  } tag_entry_t;

endpackage

`default_nettype wire

// File: icache_refill.sv
// Line refill unit: memory request, beat counting and array writes
`timescale 1ns/1ps
`default_nettype none

module icache_refill #(
  parameter int unsigned WaysWidth = 2
) (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_ni,
  input  wire logic                                    refill_start_i,
  input  wire logic [WaysWidth-1:0]                    refill_way_i,
  output logic                                         refill_done_o,
  output logic                                         refill_denied_o,
  icache_array_if.refill                               arr,
  output logic                                         mem_a_valid_o,
  input  wire logic                                    mem_a_ready_i,
  output logic [icache_geom_pkg::PhysAddrLen-1:0]      mem_a_address_o,
  input  wire logic                                    mem_d_valid_i,
  output logic                                         mem_d_ready_o,
  input  wire logic [63:0]                             mem_d_data_i,
  input  wire logic                                    mem_d_denied_i
);

  typedef enum logic [1:0] {
    Idle,
    Request,
    Beats,
    Done
  } state_e;

  state_e                                state_q;
  logic [icache_geom_pkg::BeatWidth-1:0] beat_q;
  logic                                  denied_q;
  icache_geom_pkg::icache_addr_u         line_q;
  logic [WaysWidth-1:0]                  way_q;

  logic beat_fire;
  logic last_beat;

  assign beat_fire = mem_d_valid_i && mem_d_ready_o;
  assign last_beat = beat_q == icache_geom_pkg::BeatWidth'(icache_fetch_pkg::BeatsPerLine - 1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= Idle;
      beat_q   <= '0;
      denied_q <= 1'b0;
    end else begin
      unique case (state_q)
        Idle: if (refill_start_i) state_q <= Request;
        Request: begin
          if (mem_a_ready_i) begin
            state_q  <= Beats;
            beat_q   <= '0;
            denied_q <= 1'b0;
          end
        end
        Beats: begin
          if (beat_fire) begin
            beat_q   <= beat_q + 1'b1;
            denied_q <= denied_q | mem_d_denied_i;
            if (last_beat) begin
              state_q <= Done;
            end
          end
        end
        Done: state_q <= Idle;
        default: state_q <= Idle;
      endcase
    end
  end

  // Line address and target way, held for the whole refill
  always_ff @(posedge clk_i) begin
    if (refill_start_i && state_q == Idle) begin
      line_q.raw <= {arr.rd_addr.raw[icache_geom_pkg::PhysAddrLen-1:6], 6'b0};
      way_q      <= refill_way_i;
    end
  end

  assign mem_a_valid_o   = state_q == Request;
  assign mem_a_address_o = line_q.raw;
  assign mem_d_ready_o   = state_q == Beats;

  ////////////////////////////////
  // Array writes
  ////////////////////////////////

  always_comb begin
    arr.wr_addr             = line_q;
    arr.wr_addr.fields.beat = beat_q;
  end

  assign arr.wr_way       = way_q;
  assign arr.wr_data      = mem_d_data_i;
  assign arr.wr_data_req  = beat_fire && !mem_d_denied_i;
  // Tag becomes valid only if no beat of the line was denied
  assign arr.wr_tag_req   = beat_fire && last_beat && !(denied_q || mem_d_denied_i);
  assign arr.wr_tag.tag   = line_q.fields.tag;
  assign arr.wr_tag.valid = 1'b1;

  assign refill_done_o   = state_q == Done;
  assign refill_denied_o = (state_q == Done) && denied_q;

endmodule

`default_nettype wire

// File: icache_sva.sv
// Concurrent assertions on the cache top-level ports and their bind to icache_top
`timescale 1ns/1ps
`default_nettype none

module icache_sva (
  input wire logic                                    clk_i,
  input wire logic                                    rst_ni,
  input wire logic                                    resp_valid_i,
  input wire logic                                    resp_exception_i,
  input wire logic                                    mem_a_valid_i,
  input wire logic                                    mem_a_ready_i,
  input wire logic [icache_geom_pkg::PhysAddrLen-1:0] mem_a_address_i
);

  // Responses are single-cycle pulses
  a_resp_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i |=> !resp_valid_i)
    else $error("resp_valid_o high on two consecutive cycles");

  a_exc_with_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_exception_i |-> resp_valid_i)
    else $error("resp_exception_o high without resp_valid_o");

  // Line request holds until the memory takes it
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_a_valid_i && !mem_a_ready_i |=> mem_a_valid_i && $stable(mem_a_address_i))
    else $error("mem_a request dropped or changed before mem_a_ready_i");

endmodule

bind icache_top icache_sva u_sva (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .resp_valid_i     (resp_valid_o),
  .resp_exception_i (resp_exception_o),
  .mem_a_valid_i    (mem_a_valid_o),
  .mem_a_ready_i    (mem_a_ready_i),
  .mem_a_address_i  (mem_a_address_o)
);

`default_nettype wire

// File: icache_tag_array.sv
// Tag RAMs per way, hit compare, victim choice and invalidate sweep
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array #(
  parameter int unsigned WaysWidth = 2
) (
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  icache_array_if.tag arr
);

  localparam int unsigned NumWays = 2 ** WaysWidth;
  localparam int unsigned NumSets = 2 ** icache_geom_pkg::SetsWidth;

  icache_geom_pkg::tag_entry_t tag_mem [NumWays][NumSets];
  icache_geom_pkg::tag_entry_t rd_tag_q [NumWays];
  logic [icache_geom_pkg::TagWidth-1:0] cmp_tag_q;

  logic                                  flush_busy_q;
  logic [icache_geom_pkg::SetsWidth-1:0] sweep_idx_q;
  logic [WaysWidth-1:0]                  rr_q;

  logic [NumWays-1:0]   hit_vec;
  logic [WaysWidth-1:0] sel_way;

  ////////////////////////////////
  // Invalidate sweep
  ////////////////////////////////

  // One set per cycle, starting from set 0 at reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_busy_q <= 1'b1;
      sweep_idx_q  <= '0;
    end else if (arr.flush_start) begin
      flush_busy_q <= 1'b1;
      sweep_idx_q  <= '0;
    end else if (flush_busy_q) begin
      sweep_idx_q <= sweep_idx_q + 1'b1;
      if (&sweep_idx_q) begin
        flush_busy_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////
  // Tag storage
  ////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NumWays; w++) begin
      if (flush_busy_q) begin
        tag_mem[w][sweep_idx_q] <= '0;
      end else if (arr.wr_tag_req && arr.wr_way == WaysWidth'(w)) begin
        tag_mem[w][arr.wr_addr.fields.index] <= arr.wr_tag;
      end
      if (arr.rd_req) begin
        rd_tag_q[w] <= tag_mem[w][arr.rd_addr.fields.index];
      end
    end
    if (arr.rd_req) begin
      cmp_tag_q <= arr.rd_addr.fields.tag;
    end
  end

  ////////////////////////////////
  // Hit and victim
  ////////////////////////////////

  // Round-robin fallback moves on with each allocation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (arr.alloc) begin
      rr_q <= rr_q + 1'b1;
    end
  end

  always_comb begin
    sel_way = rr_q;
    for (int i = 0; i < NumWays; i++) begin
      hit_vec[i] = rd_tag_q[i].valid && rd_tag_q[i].tag == cmp_tag_q;
    end
    // Lowest invalid way beats the pointer, a hit beats both
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (!rd_tag_q[i].valid) begin
        sel_way = WaysWidth'(i);
      end
    end
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (hit_vec[i]) begin
        sel_way = WaysWidth'(i);
      end
    end
  end

  assign arr.hit        = |hit_vec;
  assign arr.sel_way    = sel_way;
  assign arr.flush_busy = flush_busy_q;

endmodule

`default_nettype wire

// File: icache_top.sv
// Instruction cache top level with fetch and memory ports
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int unsigned WaysWidth = 2
) (
  input  wire logic                               clk_i,
  input  wire logic                               rst_ni,
  // Fetch port
  input  wire logic                               req_valid_i,
  input  wire logic [63:0]                        req_addr_i,
  input  wire logic                               req_flush_i,
  output logic                                    resp_valid_o,
  output logic [31:0]                             resp_instr_o,
  output logic                                    resp_exception_o,
  output logic [3:0]                              resp_ex_code_o,
  // Memory port
  output logic                                    mem_a_valid_o,
  input  wire logic                               mem_a_ready_i,
  output logic [icache_geom_pkg::PhysAddrLen-1:0] mem_a_address_o,
  input  wire logic                               mem_d_valid_i,
  output logic                                    mem_d_ready_o,
  input  wire logic [63:0]                        mem_d_data_i,
  input  wire logic                               mem_d_denied_i
);

  logic                 refill_start;
  logic [WaysWidth-1:0] refill_way;
  logic                 refill_done;
  logic                 refill_denied;

  icache_array_if #(.WaysWidth(WaysWidth)) arr_if ();

  icache_ctrl #(.WaysWidth(WaysWidth)) u_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_valid_i      (req_valid_i),
    .req_addr_i       (req_addr_i),
    .req_flush_i      (req_flush_i),
    .resp_valid_o     (resp_valid_o),
    .resp_instr_o     (resp_instr_o),
    .resp_exception_o (resp_exception_o),
    .resp_ex_code_o   (resp_ex_code_o),
    .arr              (arr_if.ctrl),
    .refill_start_o   (refill_start),
    .refill_way_o     (refill_way),
    .refill_done_i    (refill_done),
    .refill_denied_i  (refill_denied)
  );

  icache_refill #(.WaysWidth(WaysWidth)) u_refill (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .refill_start_i  (refill_start),
    .refill_way_i    (refill_way),
    .refill_done_o   (refill_done),
    .refill_denied_o (refill_denied),
    .arr             (arr_if.refill),
    .mem_a_valid_o   (mem_a_valid_o),
    .mem_a_ready_i   (mem_a_ready_i),
    .mem_a_address_o (mem_a_address_o),
    .mem_d_valid_i   (mem_d_valid_i),
    .mem_d_ready_o   (mem_d_ready_o),
    .mem_d_data_i    (mem_d_data_i),
    .mem_d_denied_i  (mem_d_denied_i)
  );

  icache_tag_array #(.WaysWidth(WaysWidth)) u_tag_array (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .arr    (arr_if.tag)
  );

  icache_data_array #(.WaysWidth(WaysWidth)) u_data_array (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .arr    (arr_if.data)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_icache -o sim_icache

output="$(./obj_dir/sim_icache 2>&1)" || true
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// File: tb_icache.sv
// Instruction cache testbench with clock, reset, memory model, checks and directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  localparam int unsigned WaysWidth  = 2;
  localparam int unsigned NumWays    = 1 << WaysWidth;
  // About 15 line refills of under 30 cycles each, two sweeps and reset
  localparam int          CycleLimit = 3000;
  localparam logic [3:0]  AccessFaultCode = 4'd1;
  localparam logic [31:0] WordPattern     = 32'h1234_5678;
  localparam logic [31:0] Seed            = 32'hf7d28b82;

  logic        clk_i;
  logic        rst_ni;
  logic        req_valid_i;
  logic [63:0] req_addr_i;
  logic        req_flush_i;
  logic        resp_valid_o;
  logic [31:0] resp_instr_o;
  logic        resp_exception_o;
  logic [3:0]  resp_ex_code_o;
  logic        mem_a_valid_o;
  logic        mem_a_ready_i;
  logic [31:0] mem_a_address_o;
  logic        mem_d_valid_i;
  logic        mem_d_ready_o;
  logic [63:0] mem_d_data_i;
  logic        mem_d_denied_i;

  int          cycle_cnt;
  int          req_count;
  logic        deny_refill;
  logic [31:0] last_req_line;
  logic [63:0] line_a;
  logic [63:0] line_b;

  icache_top #(.WaysWidth(WaysWidth)) UUT (.*);

  ////////////////////////////////
  // Reference model helpers
  ////////////////////////////////

  function automatic logic [31:0] model_word(input logic [31:0] a);
    return a ^ WordPattern;
  endfunction

  function automatic logic [31:0] expected_word(input logic [63:0] addr);
    return model_word({addr[31:2], 2'b00});
  endfunction

  function automatic logic [63:0] beat_data(input logic [31:0] line, input int k);
    return {model_word(line + 32'(8 * k) + 32'd4), model_word(line + 32'(8 * k))};
  endfunction

  // Tag, set index, beat and 4-byte half of a fetch address
  function automatic logic [63:0] word_addr(input logic [21:0] tag, input logic [3:0] index,
                                            input logic [2:0] beat, input logic half);
    return {32'h0, tag, index, beat, half, 2'b00};
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  ////////////////////////////////
  // Clock, watchdog and memory
  ////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CycleLimit) begin
      @(posedge clk_i);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("Timeout: the cache gave no response within %0d cycles", CycleLimit);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped by watchdog");
  end

  // Serves one line request at a time with eight beats in address order
  initial begin : memory_model
    int delay;
    logic [31:0] line;
    mem_a_ready_i  = 1'b0;
    mem_d_valid_i  = 1'b0;
    mem_d_data_i   = '0;
    mem_d_denied_i = 1'b0;
    req_count      = 0;
    forever begin
      @(posedge clk_i);
      if (mem_a_valid_o) begin
        delay = int'($urandom % 4);
        repeat (delay) @(posedge clk_i);
        mem_a_ready_i <= 1'b1;
        @(posedge clk_i);
        check_value("mem_a_valid_o", 64'(mem_a_valid_o), 64'd1);
        line = mem_a_address_o;
        check_value("mem_a_address_o[5:0]", 64'(line[5:0]), 64'd0);
        last_req_line = line;
        req_count     = req_count + 1;
        mem_a_ready_i <= 1'b0;
        for (int k = 0; k < 8; k++) begin
          mem_d_valid_i  <= 1'b1;
          mem_d_data_i   <= beat_data(line, k);
          mem_d_denied_i <= deny_refill;
          @(posedge clk_i);
          while (!mem_d_ready_o) @(posedge clk_i);
        end
        mem_d_valid_i  <= 1'b0;
        mem_d_denied_i <= 1'b0;
      end
    end
  end

  ////////////////////////////////
  // Fetch helpers
  ////////////////////////////////

  // Latency counts clock edges from the one that samples the request
  task automatic issue_fetch(input logic [63:0] addr, input logic flush,
                             output logic [31:0] instr, output logic exc,
                             output logic [3:0] code, output int latency);
    int start_cycle;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_addr_i  <= addr;
    req_flush_i <= flush;
    @(negedge clk_i);
    start_cycle = cycle_cnt;
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    req_flush_i <= 1'b0;
    @(negedge clk_i);
    while (!resp_valid_o) @(negedge clk_i);
    latency = cycle_cnt - start_cycle;
    instr   = resp_instr_o;
    exc     = resp_exception_o;
    code    = resp_ex_code_o;
  endtask

  task automatic fetch_expect_word(input logic [63:0] addr, input int new_requests);
    int          count_before;
    int          latency;
    logic [31:0] instr;
    logic        exc;
    logic [3:0]  code;
    count_before = req_count;
    issue_fetch(addr, 1'b0, instr, exc, code, latency);
    check_value("resp_exception_o", 64'(exc), 64'd0);
    check_value("resp_instr_o", 64'(instr), 64'(expected_word(addr)));
    check_value("request count", 64'(req_count), 64'(count_before + new_requests));
    if (new_requests == 0) begin
      check_value("hit latency", 64'(latency), 64'd1);
    end
  endtask

  ////////////////////////////////
  // Directed tests
  ////////////////////////////////

  task automatic miss_then_hit();
    logic [21:0] tag;
    tag    = 22'($urandom);
    line_a = word_addr(tag, 4'd1, 3'd0, 1'b0);
    fetch_expect_word(word_addr(tag, 4'd1, 3'd3, 1'b0), 1);
    check_value("mem_a_address_o", 64'(last_req_line), 64'(line_a[31:0]));
    fetch_expect_word(word_addr(tag, 4'd1, 3'd5, 1'b1), 0);
  endtask

  task automatic select_both_halves();
    logic [21:0] tag;
    tag    = 22'($urandom);
    line_b = word_addr(tag, 4'd2, 3'd0, 1'b0);
    fetch_expect_word(word_addr(tag, 4'd2, 3'd6, 1'b0), 1);
    fetch_expect_word(word_addr(tag, 4'd2, 3'd6, 1'b1), 0);
  endtask

  // Extra misses in a spare set bring the round-robin pointer back to way 0
  task automatic align_round_robin();
    logic [21:0] tag;
    tag = 22'($urandom);
    while (req_count % NumWays != 0) begin
      fetch_expect_word(word_addr(tag, 4'd3, 3'd1, 1'b0), 1);
      tag = tag + 22'd1;
    end
  endtask

  task automatic evict_round_robin();
    logic [21:0] tag;
    tag = 22'($urandom);
    for (int i = 0; i < 5; i++) begin
      fetch_expect_word(word_addr(tag + 22'(i), 4'd5, 3'(i), 1'b0), 1);
    end
    // Line 2 is checked first because refetching line 1 moves into its way
    fetch_expect_word(word_addr(tag + 22'd1, 4'd5, 3'd7, 1'b1), 0);
    fetch_expect_word(word_addr(tag, 4'd5, 3'd2, 1'b1), 1);
  endtask

  task automatic denied_then_retry();
    logic [63:0] addr;
    logic [31:0] instr;
    logic        exc;
    logic [3:0]  code;
    int          latency;
    int          count_before;
    addr         = word_addr(22'($urandom), 4'd7, 3'd4, 1'b1);
    count_before = req_count;
    deny_refill  = 1'b1;
    issue_fetch(addr, 1'b0, instr, exc, code, latency);
    check_value("resp_exception_o", 64'(exc), 64'd1);
    check_value("resp_ex_code_o", 64'(code), 64'(AccessFaultCode));
    check_value("request count", 64'(req_count), 64'(count_before + 1));
    deny_refill = 1'b0;
    fetch_expect_word(addr, 1);
  endtask

  task automatic out_of_range_fault();
    logic [63:0] addr;
    logic [31:0] instr;
    logic        exc;
    logic [3:0]  code;
    int          latency;
    int          count_before;
    addr         = {$urandom | 32'h1, $urandom & 32'hffff_fffc};
    count_before = req_count;
    issue_fetch(addr, 1'b0, instr, exc, code, latency);
    check_value("resp_exception_o", 64'(exc), 64'd1);
    check_value("resp_ex_code_o", 64'(code), 64'(AccessFaultCode));
    check_value("fault latency", 64'(latency), 64'd1);
    check_value("request count", 64'(req_count), 64'(count_before));
  endtask

  task automatic flush_then_refetch();
    logic [63:0] addr;
    logic [31:0] instr;
    logic        exc;
    logic [3:0]  code;
    int          latency;
    int          count_before;
    addr         = line_a + 64'd20;
    count_before = req_count;
    issue_fetch(addr, 1'b1, instr, exc, code, latency);
    check_value("resp_exception_o", 64'(exc), 64'd0);
    check_value("resp_instr_o", 64'(instr), 64'(expected_word(addr)));
    check_value("request count", 64'(req_count), 64'(count_before + 1));
    // Line cached before the flush has to come from memory again
    fetch_expect_word(line_b + 64'd8, 1);
  endtask

  initial begin
    void'($urandom(Seed));
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_flush_i = 1'b0;
    deny_refill = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("resp_valid_o", 64'(resp_valid_o), 64'd0);
    check_value("resp_exception_o", 64'(resp_exception_o), 64'd0);
    check_value("mem_a_valid_o", 64'(mem_a_valid_o), 64'd0);
    // First fetch lands in the reset sweep and waits for it
    miss_then_hit();
    select_both_halves();
    align_round_robin();
    evict_round_robin();
    denied_then_retry();
    out_of_range_fault();
    flush_then_refetch();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire
